// ==== axi_defs_pkg.sv ====
package axi_defs_pkg;

  // response code for every B and R beat
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // burst length field, beats minus one
  typedef logic [7:0] axi_len_t;

  // defaults for the top level widths
  localparam int DEF_ADDR_WIDTH = 20;
  localparam int DEF_DATA_WIDTH = 16;
  localparam int DEF_ID_WIDTH = 4;

endpackage

// ==== sram_defs_pkg.sv ====
package sram_defs_pkg;

  // meta layout is {id, last}, last in the low bit
  localparam int META_LAST_BIT = 0;
  localparam int META_ID_LSB = 1;

  function automatic int meta_width(input int id_width);
    return id_width + 1;
  endfunction

  // byte address bits below one data word
  function automatic int word_lsb(input int data_width);
    return $clog2(data_width) - 3;
  endfunction

endpackage

// ==== sram_cmd_if.sv ====
interface sram_cmd_if #(
  parameter int AXI_ADDR_WIDTH = axi_defs_pkg::DEF_ADDR_WIDTH,
  parameter int AXI_DATA_WIDTH = axi_defs_pkg::DEF_DATA_WIDTH,
  parameter int AXI_ID_WIDTH = axi_defs_pkg::DEF_ID_WIDTH
);
  localparam int ADDR_WIDTH = AXI_ADDR_WIDTH - sram_defs_pkg::word_lsb(AXI_DATA_WIDTH);
  localparam int META_WIDTH = sram_defs_pkg::meta_width(AXI_ID_WIDTH);
  localparam int STRB_WIDTH = AXI_DATA_WIDTH / 8;

  logic                      valid;
  logic                      ready;
  logic                      wr_en;
  // word address, not byte address
  logic [    ADDR_WIDTH-1:0] addr;
  logic [    META_WIDTH-1:0] meta;
  logic [AXI_DATA_WIDTH-1:0] wr_data;
  logic [    STRB_WIDTH-1:0] wr_strb;

  modport src(output valid, wr_en, addr, meta, wr_data, wr_strb, input ready);
  modport dst(input valid, wr_en, addr, meta, wr_data, wr_strb, output ready);

endinterface

// ==== sram_rsp_if.sv ====
interface sram_rsp_if #(
  parameter int AXI_DATA_WIDTH = axi_defs_pkg::DEF_DATA_WIDTH,
  parameter int AXI_ID_WIDTH = axi_defs_pkg::DEF_ID_WIDTH
);
  localparam int META_WIDTH = sram_defs_pkg::meta_width(AXI_ID_WIDTH);

  logic                      valid;
  logic                      ready;
  logic [AXI_DATA_WIDTH-1:0] data;
  // meta comes back exactly as it went out with the read command
  logic [    META_WIDTH-1:0] meta;

  modport src(output valid, data, meta, input ready);
  modport dst(input valid, data, meta, output ready);

endinterface

// ==== axi_sram_wr.sv ====
module axi_sram_wr #(
  parameter int AXI_ADDR_WIDTH = axi_defs_pkg::DEF_ADDR_WIDTH,
  parameter int AXI_DATA_WIDTH = axi_defs_pkg::DEF_DATA_WIDTH,
  parameter int AXI_ID_WIDTH = axi_defs_pkg::DEF_ID_WIDTH
) (
  input  logic                        clk,
  input  logic                        i_rst_n,
  input  logic                        i_axi_awvalid,
  output logic                        o_axi_awready,
  input  logic [    AXI_ID_WIDTH-1:0] i_axi_awid,
  input  logic [  AXI_ADDR_WIDTH-1:0] i_axi_awaddr,
  input  logic                        i_axi_wvalid,
  output logic                        o_axi_wready,
  input  logic [  AXI_DATA_WIDTH-1:0] i_axi_wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0] i_axi_wstrb,
  input  logic                        i_axi_wlast,
  output logic                        o_axi_bvalid,
  input  logic                        i_axi_bready,
  output logic [    AXI_ID_WIDTH-1:0] o_axi_bid,
  output logic [                 1:0] o_axi_bresp,
  sram_cmd_if.src                     o_cmd
);
  localparam int LSB = sram_defs_pkg::word_lsb(AXI_DATA_WIDTH);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_RESP
  } state_t;

  state_t                        state;
  logic [AXI_ADDR_WIDTH-LSB-1:0] wr_addr;
  logic [    AXI_ID_WIDTH-1:0]   burst_id;

  // each W beat goes straight out as one write command
  assign o_cmd.valid   = (state == ST_DATA) && i_axi_wvalid;
  assign o_cmd.wr_en   = 1'b1;
  assign o_cmd.addr    = wr_addr;
  assign o_cmd.meta    = {burst_id, i_axi_wlast};
  assign o_cmd.wr_data = i_axi_wdata;
  assign o_cmd.wr_strb = i_axi_wstrb;

  assign o_axi_wready  = (state == ST_DATA) && o_cmd.ready;
  assign o_axi_bid     = burst_id;
  assign o_axi_bresp   = axi_defs_pkg::RESP_OKAY;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state         <= ST_IDLE;
      o_axi_awready <= 1'b0;
      o_axi_bvalid  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_axi_awvalid && o_axi_awready) begin
            state         <= ST_DATA;
            o_axi_awready <= 1'b0;
          end else begin
            o_axi_awready <= 1'b1;
          end
        end
        ST_DATA: begin
          if (i_axi_wvalid && o_axi_wready && i_axi_wlast) begin
            state        <= ST_RESP;
            o_axi_bvalid <= 1'b1;
          end
        end
        ST_RESP: begin
          // one burst in flight, so AW opens again only after B
          if (i_axi_bready) begin
            state         <= ST_IDLE;
            o_axi_bvalid  <= 1'b0;
            o_axi_awready <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_axi_awvalid && o_axi_awready) begin
      burst_id <= i_axi_awid;
      wr_addr  <= i_axi_awaddr[AXI_ADDR_WIDTH-1:LSB];
    end else if (i_axi_wvalid && o_axi_wready) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

endmodule

// ==== axi_sram_rd.sv ====
module axi_sram_rd #(
  parameter int AXI_ADDR_WIDTH = axi_defs_pkg::DEF_ADDR_WIDTH,
  parameter int AXI_DATA_WIDTH = axi_defs_pkg::DEF_DATA_WIDTH,
  parameter int AXI_ID_WIDTH = axi_defs_pkg::DEF_ID_WIDTH
) (
  input  logic                          clk,
  input  logic                          i_rst_n,
  input  logic                          i_axi_arvalid,
  output logic                          o_axi_arready,
  input  logic [      AXI_ID_WIDTH-1:0] i_axi_arid,
  input  logic [    AXI_ADDR_WIDTH-1:0] i_axi_araddr,
  input  axi_defs_pkg::axi_len_t        i_axi_arlen,
  output logic                          o_axi_rvalid,
  input  logic                          i_axi_rready,
  output logic [      AXI_ID_WIDTH-1:0] o_axi_rid,
  output logic [    AXI_DATA_WIDTH-1:0] o_axi_rdata,
  output logic [                   1:0] o_axi_rresp,
  output logic                          o_axi_rlast,
  sram_cmd_if.src                       o_cmd,
  sram_rsp_if.dst                       i_rsp
);
  localparam int LSB = sram_defs_pkg::word_lsb(AXI_DATA_WIDTH);
  localparam int ID_LSB = sram_defs_pkg::META_ID_LSB;

  logic                          busy;
  logic [AXI_ADDR_WIDTH-LSB-1:0] rd_addr;
  logic [    AXI_ID_WIDTH-1:0]   burst_id;
  axi_defs_pkg::axi_len_t        beats_left;
  logic                          last_cmd;

  assign last_cmd      = (beats_left == '0);

  // command side, one read per beat
  assign o_cmd.valid   = busy;
  assign o_cmd.wr_en   = 1'b0;
  assign o_cmd.addr    = rd_addr;
  assign o_cmd.meta    = {burst_id, last_cmd};
  assign o_cmd.wr_data = '0;
  assign o_cmd.wr_strb = '0;

  // response side maps straight onto R
  assign o_axi_rvalid  = i_rsp.valid;
  assign o_axi_rdata   = i_rsp.data;
  assign o_axi_rid     = i_rsp.meta[ID_LSB+AXI_ID_WIDTH-1:ID_LSB];
  assign o_axi_rlast   = i_rsp.meta[sram_defs_pkg::META_LAST_BIT];
  assign o_axi_rresp   = axi_defs_pkg::RESP_OKAY;
  assign i_rsp.ready   = i_axi_rready;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      busy          <= 1'b0;
      o_axi_arready <= 1'b0;
    end else if (i_axi_arvalid && o_axi_arready) begin
      busy          <= 1'b1;
      o_axi_arready <= 1'b0;
    end else if (busy) begin
      // next burst may start once the last command is out
      if (o_cmd.ready && last_cmd) begin
        busy          <= 1'b0;
        o_axi_arready <= 1'b1;
      end
    end else begin
      o_axi_arready <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_axi_arvalid && o_axi_arready) begin
      burst_id   <= i_axi_arid;
      rd_addr    <= i_axi_araddr[AXI_ADDR_WIDTH-1:LSB];
      beats_left <= i_axi_arlen;
    end else if (busy && o_cmd.ready) begin
      rd_addr    <= rd_addr + 1'b1;
      beats_left <= beats_left - 1'b1;
    end
  end

endmodule

// ==== sram_cmd_arb.sv ====
module sram_cmd_arb (
  input logic     clk,
  input logic     i_rst_n,
  sram_cmd_if.dst i_wr,
  sram_cmd_if.dst i_rd,
  sram_cmd_if.src o_mem
);
  // high when the last transfer came from the read side
  logic last_rd;
  logic grant_rd;

  always_comb begin
    if (i_wr.valid && i_rd.valid) begin
      grant_rd = !last_rd;
    end else begin
      grant_rd = i_rd.valid;
    end
  end

  assign o_mem.valid   = i_wr.valid || i_rd.valid;
  assign o_mem.wr_en   = grant_rd ? i_rd.wr_en : i_wr.wr_en;
  assign o_mem.addr    = grant_rd ? i_rd.addr : i_wr.addr;
  assign o_mem.meta    = grant_rd ? i_rd.meta : i_wr.meta;
  assign o_mem.wr_data = grant_rd ? i_rd.wr_data : i_wr.wr_data;
  assign o_mem.wr_strb = grant_rd ? i_rd.wr_strb : i_wr.wr_strb;

  // the side that lost sees ready low
  assign i_wr.ready    = !grant_rd && o_mem.ready;
  assign i_rd.ready    = grant_rd && o_mem.ready;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      last_rd <= 1'b0;
    end else if (o_mem.valid && o_mem.ready) begin
      last_rd <= grant_rd;
    end
  end

endmodule

// ==== sram_mem.sv ====
module sram_mem #(
  parameter int AXI_DATA_WIDTH = axi_defs_pkg::DEF_DATA_WIDTH,
  parameter int AXI_ID_WIDTH = axi_defs_pkg::DEF_ID_WIDTH,
  parameter int MEM_WORDS = 256
) (
  input logic     clk,
  input logic     i_rst_n,
  sram_cmd_if.dst i_cmd,
  sram_rsp_if.src o_rsp
);
  localparam int IDX_WIDTH = $clog2(MEM_WORDS);
  localparam int META_WIDTH = sram_defs_pkg::meta_width(AXI_ID_WIDTH);

  logic [AXI_DATA_WIDTH-1:0] mem      [MEM_WORDS];
  logic [     IDX_WIDTH-1:0] idx;
  logic                      cmd_fire;
  logic                      rsp_valid;
  logic [AXI_DATA_WIDTH-1:0] rsp_data;
  logic [    META_WIDTH-1:0] rsp_meta;

  // upper word address bits fall away
  assign idx         = i_cmd.addr[IDX_WIDTH-1:0];
  assign i_cmd.ready = !rsp_valid || o_rsp.ready;
  assign cmd_fire    = i_cmd.valid && i_cmd.ready;

  assign o_rsp.valid = rsp_valid;
  assign o_rsp.data  = rsp_data;
  assign o_rsp.meta  = rsp_meta;

  always_ff @(posedge clk) begin
    if (cmd_fire && i_cmd.wr_en) begin
      for (int b = 0; b < AXI_DATA_WIDTH / 8; b++) begin
        if (i_cmd.wr_strb[b]) begin
          mem[idx][b*8+:8] <= i_cmd.wr_data[b*8+:8];
        end
      end
    end
  end

  // one-entry response register
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      rsp_valid <= 1'b0;
    end else if (cmd_fire && !i_cmd.wr_en) begin
      rsp_valid <= 1'b1;
    end else if (o_rsp.ready) begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire && !i_cmd.wr_en) begin
      rsp_data <= mem[idx];
      rsp_meta <= i_cmd.meta;
    end
  end

endmodule

// ==== axi_sram_top.sv ====
module axi_sram_top #(
  parameter int AXI_ADDR_WIDTH = axi_defs_pkg::DEF_ADDR_WIDTH,
  parameter int AXI_DATA_WIDTH = axi_defs_pkg::DEF_DATA_WIDTH,
  parameter int AXI_ID_WIDTH = axi_defs_pkg::DEF_ID_WIDTH,
  parameter int MEM_WORDS = 256
) (
  input  logic                        clk,
  input  logic                        i_rst_n,
  input  logic                        i_axi_awvalid,
  output logic                        o_axi_awready,
  input  logic [    AXI_ID_WIDTH-1:0] i_axi_awid,
  input  logic [  AXI_ADDR_WIDTH-1:0] i_axi_awaddr,
  input  axi_defs_pkg::axi_len_t      i_axi_awlen,
  input  logic [                 2:0] i_axi_awsize,
  input  logic [                 1:0] i_axi_awburst,
  input  logic                        i_axi_wvalid,
  output logic                        o_axi_wready,
  input  logic [  AXI_DATA_WIDTH-1:0] i_axi_wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0] i_axi_wstrb,
  input  logic                        i_axi_wlast,
  output logic                        o_axi_bvalid,
  input  logic                        i_axi_bready,
  output logic [    AXI_ID_WIDTH-1:0] o_axi_bid,
  output logic [                 1:0] o_axi_bresp,
  input  logic                        i_axi_arvalid,
  output logic                        o_axi_arready,
  input  logic [    AXI_ID_WIDTH-1:0] i_axi_arid,
  input  logic [  AXI_ADDR_WIDTH-1:0] i_axi_araddr,
  input  axi_defs_pkg::axi_len_t      i_axi_arlen,
  input  logic [                 2:0] i_axi_arsize,
  input  logic [                 1:0] i_axi_arburst,
  output logic                        o_axi_rvalid,
  input  logic                        i_axi_rready,
  output logic [    AXI_ID_WIDTH-1:0] o_axi_rid,
  output logic [  AXI_DATA_WIDTH-1:0] o_axi_rdata,
  output logic [                 1:0] o_axi_rresp,
  output logic                        o_axi_rlast
);
  // every burst is full width INCR, and writes end on wlast rather than awlen

  sram_cmd_if #(
    .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH),
    .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
    .AXI_ID_WIDTH  (AXI_ID_WIDTH)
  ) wr_cmd ();

  sram_cmd_if #(
    .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH),
    .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
    .AXI_ID_WIDTH  (AXI_ID_WIDTH)
  ) rd_cmd ();

  sram_cmd_if #(
    .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH),
    .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
    .AXI_ID_WIDTH  (AXI_ID_WIDTH)
  ) mem_cmd ();

  sram_rsp_if #(
    .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
    .AXI_ID_WIDTH  (AXI_ID_WIDTH)
  ) mem_rsp ();

  axi_sram_wr #(
    .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH),
    .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
    .AXI_ID_WIDTH  (AXI_ID_WIDTH)
  ) axi_sram_wr_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_axi_awvalid(i_axi_awvalid),
    .o_axi_awready(o_axi_awready),
    .i_axi_awid   (i_axi_awid),
    .i_axi_awaddr (i_axi_awaddr),
    .i_axi_wvalid (i_axi_wvalid),
    .o_axi_wready (o_axi_wready),
    .i_axi_wdata  (i_axi_wdata),
    .i_axi_wstrb  (i_axi_wstrb),
    .i_axi_wlast  (i_axi_wlast),
    .o_axi_bvalid (o_axi_bvalid),
    .i_axi_bready (i_axi_bready),
    .o_axi_bid    (o_axi_bid),
    .o_axi_bresp  (o_axi_bresp),
    .o_cmd        (wr_cmd)
  );

  axi_sram_rd #(
    .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH),
    .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
    .AXI_ID_WIDTH  (AXI_ID_WIDTH)
  ) axi_sram_rd_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_axi_arvalid(i_axi_arvalid),
    .o_axi_arready(o_axi_arready),
    .i_axi_arid   (i_axi_arid),
    .i_axi_araddr (i_axi_araddr),
    .i_axi_arlen  (i_axi_arlen),
    .o_axi_rvalid (o_axi_rvalid),
    .i_axi_rready (i_axi_rready),
    .o_axi_rid    (o_axi_rid),
    .o_axi_rdata  (o_axi_rdata),
    .o_axi_rresp  (o_axi_rresp),
    .o_axi_rlast  (o_axi_rlast),
    .o_cmd        (rd_cmd),
    .i_rsp        (mem_rsp)
  );

  sram_cmd_arb sram_cmd_arb_i (
    .clk    (clk),
    .i_rst_n(i_rst_n),
    .i_wr   (wr_cmd),
    .i_rd   (rd_cmd),
    .o_mem  (mem_cmd)
  );

  sram_mem #(
    .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
    .AXI_ID_WIDTH  (AXI_ID_WIDTH),
    .MEM_WORDS     (MEM_WORDS)
  ) sram_mem_i (
    .clk    (clk),
    .i_rst_n(i_rst_n),
    .i_cmd  (mem_cmd),
    .o_rsp  (mem_rsp)
  );

endmodule

// ==== tb_axi_sram.sv ====
module tb_axi_sram;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int AW = axi_defs_pkg::DEF_ADDR_WIDTH;
  localparam int DW = axi_defs_pkg::DEF_DATA_WIDTH;
  localparam int IW = axi_defs_pkg::DEF_ID_WIDTH;
  localparam int WORDS = 256;
  localparam int IDX = $clog2(WORDS);
  // byte address bits below one data word
  localparam int LSB = $clog2(DW / 8);
  localparam int TIMEOUT = 1000;

  typedef struct packed {
    logic [IW-1:0] id;
    logic          last;
    logic [DW-1:0] data;
  } r_beat_t;

  logic clk = 1'b0;
  logic i_rst_n;
  logic i_axi_awvalid, o_axi_awready, i_axi_wvalid, o_axi_wready, i_axi_wlast;
  logic i_axi_arvalid, o_axi_arready, o_axi_bvalid, i_axi_bready;
  logic o_axi_rvalid, i_axi_rready, o_axi_rlast;
  logic [IW-1:0] i_axi_awid, o_axi_bid, i_axi_arid, o_axi_rid;
  logic [AW-1:0] i_axi_awaddr, i_axi_araddr;
  logic [DW-1:0] i_axi_wdata, o_axi_rdata;
  logic [DW/8-1:0] i_axi_wstrb;
  logic [2:0] i_axi_awsize, i_axi_arsize;
  logic [1:0] i_axi_awburst, i_axi_arburst, o_axi_bresp, o_axi_rresp;
  axi_defs_pkg::axi_len_t i_axi_awlen, i_axi_arlen;

  logic [31:0] lcg_state = 32'h5187;
  logic [DW-1:0] ref_mem[WORDS];
  logic [IDX-1:0] mdl_waddr;
  logic [IW-1:0] exp_bid;
  r_beat_t exp_q[$];
  r_beat_t exp_head;
  logic exp_avail;
  int mismatch_count = 0;
  int failure_count = 0;

  axi_sram_top axi_sram_top_i (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic pick_rready(input bit gaps);
    logic [31:0] rnd;
    if (!gaps) begin
      return 1'b1;
    end
    rnd = lcg_next();
    return rnd[23:22] != 2'b00;
  endfunction

  // pattern over all index bits
  function automatic logic [DW-1:0] fill_word(input logic [IDX-1:0] idx);
    return {idx ^ 8'h5a, ~idx};
  endfunction

  task automatic report_failure(input string msg);
    failure_count++;
    $display("%s at %0t", msg, $time);
  endtask

  // memory model and expected R beats, updated on each handshake
  always @(posedge clk) begin
    r_beat_t beat_e;
    logic [IDX-1:0] ridx;
    if (i_rst_n) begin
      if (r_handshake()) begin
        void'(exp_q.pop_front());
      end
      if (i_axi_awvalid && o_axi_awready) begin
        mdl_waddr = i_axi_awaddr[LSB+:IDX];
        exp_bid = i_axi_awid;
      end
      if (i_axi_wvalid && o_axi_wready) begin
        for (int b = 0; b < DW / 8; b++) begin
          if (i_axi_wstrb[b]) begin
            ref_mem[mdl_waddr][b*8+:8] = i_axi_wdata[b*8+:8];
          end
        end
        mdl_waddr = mdl_waddr + 1'b1;
      end
      if (i_axi_arvalid && o_axi_arready) begin
        ridx = i_axi_araddr[LSB+:IDX];
        for (int n = 0; n <= int'(i_axi_arlen); n++) begin
          beat_e.data = ref_mem[ridx];
          beat_e.id = i_axi_arid;
          beat_e.last = (n == int'(i_axi_arlen));
          exp_q.push_back(beat_e);
          ridx = ridx + 1'b1;
        end
      end
      exp_avail = (exp_q.size() > 0);
      if (exp_avail) begin
        exp_head = exp_q[0];
      end
    end
  end

  function automatic logic r_handshake();
    return o_axi_rvalid && i_axi_rready;
  endfunction

  reset_state: assert property (@(posedge clk)
      $rose(i_rst_n) |-> (!o_axi_bvalid && !o_axi_rvalid && !o_axi_wready))
    else begin
      mismatch_count++;
      $display("Mismatch at %0t: bvalid, rvalid or wready high after reset", $time);
    end

  ready_after_reset: assert property (@(posedge clk)
      $rose(i_rst_n) |=> (o_axi_awready && o_axi_arready))
    else begin
      mismatch_count++;
      $display("Mismatch at %0t: awready or arready low after reset", $time);
    end

  b_fields: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_axi_bvalid |-> (o_axi_bid == exp_bid && o_axi_bresp == axi_defs_pkg::RESP_OKAY))
    else begin
      mismatch_count++;
      $display("Mismatch at %0t: bid %h bresp %h, expected bid %h with OKAY",
               $time, $sampled(o_axi_bid), $sampled(o_axi_bresp), $sampled(exp_bid));
    end

  b_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_axi_bvalid && !i_axi_bready) |=> (o_axi_bvalid && $stable(o_axi_bid)))
    else begin
      mismatch_count++;
      $display("Mismatch at %0t: B response changed while bready was low", $time);
    end

  aw_blocked: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_axi_bvalid |-> !o_axi_awready)
    else begin
      mismatch_count++;
      $display("Mismatch at %0t: awready high before B was taken", $time);
    end

  r_beat: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_axi_rvalid && i_axi_rready) |-> (exp_avail && o_axi_rdata == exp_head.data
      && o_axi_rid == exp_head.id && o_axi_rlast == exp_head.last
      && o_axi_rresp == axi_defs_pkg::RESP_OKAY))
    else begin
      mismatch_count++;
      $display("Mismatch at %0t: R beat data %h id %h last %b, model data %h id %h last %b",
               $time, $sampled(o_axi_rdata), $sampled(o_axi_rid), $sampled(o_axi_rlast),
               $sampled(exp_head.data), $sampled(exp_head.id), $sampled(exp_head.last));
    end

  r_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_axi_rvalid && !i_axi_rready) |=> (o_axi_rvalid && $stable(o_axi_rdata)
      && $stable(o_axi_rid) && $stable(o_axi_rlast)))
    else begin
      mismatch_count++;
      $display("Mismatch at %0t: R beat changed while rready was low", $time);
    end

  task automatic write_burst(input logic [IW-1:0] id, input logic [AW-1:0] addr,
                             input int len, input bit fill, input logic [DW-1:0] fill_xor,
                             input int bready_hold);
    int cycles;
    logic [31:0] rnd;
    logic [IDX-1:0] widx;
    @(negedge clk);
    i_axi_awvalid = 1'b1;
    i_axi_awid = id;
    i_axi_awaddr = addr;
    i_axi_awlen = axi_defs_pkg::axi_len_t'(len);
    widx = addr[LSB+:IDX];
    cycles = 0;
    @(posedge clk);
    while (!o_axi_awready && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!o_axi_awready) report_failure("timeout waiting for the AW handshake");
    for (int beat = 0; beat <= len; beat++) begin
      @(negedge clk);
      i_axi_awvalid = 1'b0;
      i_axi_wvalid = 1'b1;
      i_axi_wlast = (beat == len);
      if (fill) begin
        i_axi_wdata = fill_word(widx) ^ fill_xor;
        i_axi_wstrb = '1;
      end else begin
        rnd = lcg_next();
        i_axi_wdata = rnd[31:16];
        i_axi_wstrb = rnd[13:12];
      end
      widx = widx + 1'b1;
      cycles = 0;
      @(posedge clk);
      while (!o_axi_wready && cycles < TIMEOUT) begin
        @(posedge clk);
        cycles++;
      end
      if (!o_axi_wready) report_failure("timeout waiting for a W beat to be taken");
    end
    @(negedge clk);
    i_axi_wvalid = 1'b0;
    i_axi_wlast = 1'b0;
    i_axi_bready = (bready_hold == 0);
    cycles = 0;
    @(posedge clk);
    while (!o_axi_bvalid && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!o_axi_bvalid) report_failure("timeout waiting for the B response");
    // stall B for a while so bvalid has to hold
    if (bready_hold > 0) begin
      repeat (bready_hold) @(negedge clk);
      i_axi_bready = 1'b1;
      @(posedge clk);
    end
    @(negedge clk);
    i_axi_bready = 1'b0;
  endtask

  task automatic read_burst(input logic [IW-1:0] id, input logic [AW-1:0] addr,
                            input int len, input bit gaps);
    int cycles;
    int got;
    @(negedge clk);
    i_axi_arvalid = 1'b1;
    i_axi_arid = id;
    i_axi_araddr = addr;
    i_axi_arlen = axi_defs_pkg::axi_len_t'(len);
    cycles = 0;
    @(posedge clk);
    while (!o_axi_arready && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!o_axi_arready) report_failure("timeout waiting for the AR handshake");
    @(negedge clk);
    i_axi_arvalid = 1'b0;
    i_axi_rready = pick_rready(gaps);
    got = 0;
    cycles = 0;
    while (got <= len && cycles < TIMEOUT) begin
      @(posedge clk);
      if (o_axi_rvalid && i_axi_rready) got++;
      cycles++;
      @(negedge clk);
      i_axi_rready = pick_rready(gaps);
    end
    i_axi_rready = 1'b0;
    if (got <= len) report_failure("timeout waiting for the R beats of a burst");
  endtask

  initial begin
    logic [31:0] rnd;
    i_rst_n = 1'b0;
    {i_axi_awvalid, i_axi_wvalid, i_axi_wlast, i_axi_bready} = '0;
    {i_axi_arvalid, i_axi_rready} = '0;
    {i_axi_awid, i_axi_awaddr, i_axi_awlen, i_axi_wdata, i_axi_wstrb} = '0;
    {i_axi_arid, i_axi_araddr, i_axi_arlen} = '0;
    i_axi_awsize = 3'd1;
    i_axi_arsize = 3'd1;
    i_axi_awburst = 2'b01;
    i_axi_arburst = 2'b01;
    exp_bid = '0;
    exp_avail = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;

    // whole memory gets a known pattern first
    write_burst(4'h1, '0, WORDS - 1, 1'b1, '0, 0);
    // full strobes and data that differs from the pattern
    write_burst(4'h3, 20'h00042, 0, 1'b1, 16'h3c3c, 0);
    read_burst(4'h5, 20'h00042, 0, 1'b0);

    // random bursts read back with rready gaps
    for (int i = 0; i < 4; i++) begin
      rnd = lcg_next();
      write_burst(rnd[27:24], {11'd0, rnd[8:0]}, int'(rnd[20:16]), 1'b0, '0, 0);
      read_burst(~rnd[27:24], {11'd0, rnd[8:0]}, int'(rnd[20:16]), 1'b1);
    end

    // write and read to disjoint words in the same cycle
    fork
      write_burst(4'h9, 20'h00000, 7, 1'b1, 16'hffff, 0);
      read_burst(4'ha, 20'h00100, 7, 1'b0);
    join
    read_burst(4'hb, 20'h00000, 7, 1'b1);

    write_burst(4'hc, 20'h00080, 3, 1'b0, '0, 6);
    read_burst(4'hd, 20'h00080, 3, 1'b0);

    repeat (3) @(negedge clk);
    beats_drained: assert (exp_q.size() == 0)
      else begin
        failure_count++;
        $display("%0d expected read beats never arrived", exp_q.size());
      end
    $display("checks done: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
axi_defs_pkg.sv
sram_defs_pkg.sv
sram_cmd_if.sv
sram_rsp_if.sv
axi_sram_wr.sv
axi_sram_rd.sv
sram_cmd_arb.sv
sram_mem.sv
axi_sram_top.sv
tb_axi_sram.sv

// ==== Bender.yml ====
package:
  name: axi_sram

sources:
  - axi_defs_pkg.sv
  - sram_defs_pkg.sv
  - sram_cmd_if.sv
  - sram_rsp_if.sv
  - axi_sram_wr.sv
  - axi_sram_rd.sv
  - sram_cmd_arb.sv
  - sram_mem.sv
  - axi_sram_top.sv
  - target: test
    files:
      - tb_axi_sram.sv
